/* build.f */
verilog/lx_pkg.sv
verilog/lx_req_if.sv
verilog/lx_resp_if.sv
verilog/ulc_request_arbiter.sv
verilog/mm_beat_sequencer.sv
verilog/ulc_response_router.sv
verilog/lxbypass_top.sv
verif/mm_responder.sv
verif/tb_lxbypass.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_lxbypass
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_lxbypass.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lxbypass;
  import lx_pkg::*;

  localparam int          NUM_ULC       = 2;
  localparam int          ABW           = 12;
  localparam int          TXN_PER_CACHE = 40;
  localparam int          MAX_CYCLES    = NUM_ULC * TXN_PER_CACHE * 40;
  localparam logic [31:0] SEED          = 32'h1775cac4;

  logic                       clock   = 1'b0;
  logic                       reset   = 1'b1;
  logic [MSGW*NUM_ULC-1:0]    msg_in  = '0;
  logic [ABW*NUM_ULC-1:0]     address = '0;
  logic [ULC_DBW*NUM_ULC-1:0] data_in = '0;
  logic [MSGW*NUM_ULC-1:0]    msg_out;
  logic [ABW*NUM_ULC-1:0]     out_address;
  logic [ULC_DBW*NUM_ULC-1:0] data_out;
  msg_t                       mm2lxb_msg;
  msg_t                       lxb2mm_msg;
  logic [MM_DBW-1:0]          mm2lxb_data;
  logic [MM_DBW-1:0]          lxb2mm_data;
  logic [ABW-1:0]             lxb2mm_address;

  // Cache model, driver side
  integer             seed    = SEED;
  logic               started = 1'b0;
  logic [NUM_ULC-1:0] is_wr;
  logic [ABW-1:0]     req_addr [NUM_ULC];
  logic [ULC_DBW-1:0] req_line [NUM_ULC];
  int                 issued [NUM_ULC];
  int                 idle [NUM_ULC];

  // Reference model, monitor side
  logic [MM_DBW-1:0]  shadow [2**ABW];
  int                 resp_count [NUM_ULC];
  logic [NUM_ULC-1:0] pend_d1  = '0;  // Open requests one edge back
  logic [NUM_ULC-1:0] pend_d2  = '0;  // Two edges back
  int                 owner    = NUM_ULC - 1;  // Round robin starts at cache 0
  int                 mbeat    = 0;
  logic               mem_done = 1'b0;
  msg_t               prev_msg = NO_REQ;
  logic               prev_hs  = 1'b0;
  logic [ABW-1:0]     prev_addr;
  logic [MM_DBW-1:0]  prev_data;
  int                 errors   = 0;
  int                 cycles   = 0;
  int                 done_txn = 0;

  lxbypass_top #(.NUM_ULC(NUM_ULC), .ABW(ABW)) DUT (
    .clock(clock), .reset(reset), .msg_in(msg_in), .address(address), .data_in(data_in),
    .msg_out(msg_out), .out_address(out_address), .data_out(data_out),
    .mm2lxb_msg(mm2lxb_msg), .mm2lxb_data(mm2lxb_data), .lxb2mm_msg(lxb2mm_msg),
    .lxb2mm_address(lxb2mm_address), .lxb2mm_data(lxb2mm_data)
  );

  mm_responder #(.ABW(ABW), .SEED(SEED)) u_memory (
    .clock(clock), .reset(reset), .lxb2mm_msg(lxb2mm_msg), .lxb2mm_address(lxb2mm_address),
    .lxb2mm_data(lxb2mm_data), .mm2lxb_msg(mm2lxb_msg), .mm2lxb_data(mm2lxb_data)
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [MM_DBW-1:0] fill_word(input int a);
    return (32'(a) * 32'h9e3779b1) ^ 32'hc3c3c3c3;
  endfunction

  function automatic logic open_req(input int c);
    return issued[c] > resp_count[c];
  endfunction

  task automatic flag_error(input string what);
    errors++;
    $display("[ERROR] %0t: %s", $time, what);
  endtask

  // --------------------------------------------------------------------------
  // Caches, one request each at a time
  // --------------------------------------------------------------------------
  always @(negedge clock) begin
    logic [31:0] rnd;
    if (!reset) begin
      for (int c = 0; c < NUM_ULC; c++) begin
        if (msg_in[c*MSGW +: MSGW] != NO_REQ) begin
          if (!open_req(c)) begin  // Answered, let go
            msg_in[c*MSGW +: MSGW] = NO_REQ;
            idle[c] = int'(rand32() % 32'd3);
          end
        end else if (idle[c] > 0) begin
          idle[c]--;
        end else if (issued[c] < TXN_PER_CACHE) begin
          rnd         = rand32();
          is_wr[c]    = rnd[0];
          req_addr[c] = rnd[12:1];
          for (int k = 0; k < BEATS; k++) begin
            req_line[c][k*MM_DBW +: MM_DBW] = rand32();
          end
          msg_in[c*MSGW +: MSGW]        = rnd[0] ? WB_REQ : R_REQ;
          address[c*ABW +: ABW]         = req_addr[c];
          data_in[c*ULC_DBW +: ULC_DBW] = req_line[c];
          issued[c]++;
          started = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Monitor and reference model
  // --------------------------------------------------------------------------
  always @(posedge clock) begin
    logic               hs;
    int                 pick;
    msg_t               slice;
    logic [ULC_DBW-1:0] exp_line;
    if (reset) begin
      for (int a = 0; a < 2**ABW; a++) begin
        shadow[a] = fill_word(a);
      end
    end else begin
      cycles++;
      hs = (lxb2mm_msg == WB_REQ && mm2lxb_msg == MEM_READY) ||
           (lxb2mm_msg == R_REQ && mm2lxb_msg == MEM_SENT);
      if (!started && (lxb2mm_msg != NO_REQ || msg_out != '0))
        flag_error("bridge active before the first request");
      if (lxb2mm_msg != NO_REQ && prev_msg == NO_REQ) begin
        // Grant taken on the launch edge two edges back
        pick = -1;
        for (int k = 1; k <= NUM_ULC; k++) begin
          if (pick < 0 && pend_d2[(owner + k) % NUM_ULC])
            pick = (owner + k) % NUM_ULC;
        end
        if (pick < 0) begin
          flag_error($sformatf("memory request %0d at %h with no cache requesting",
                               lxb2mm_msg, lxb2mm_address));
        end else begin
          if (lxb2mm_msg != (is_wr[pick] ? WB_REQ : R_REQ) ||
              lxb2mm_address != req_addr[pick])
            flag_error($sformatf("memory request %0d at %h is not the one of cache %0d",
                                 lxb2mm_msg, lxb2mm_address, pick));
          owner = pick;
          mbeat = 0;
        end
      end
      if (hs) begin
        if (mbeat >= BEATS) begin
          flag_error("memory beat after the fourth one");
        end else begin
          if (lxb2mm_address != req_addr[owner] + ABW'(mbeat))
            flag_error($sformatf("beat %0d address %h, expected %h", mbeat, lxb2mm_address,
                                 req_addr[owner] + ABW'(mbeat)));
          if (lxb2mm_msg == WB_REQ &&
              lxb2mm_data != req_line[owner][mbeat*MM_DBW +: MM_DBW])
            flag_error($sformatf("write beat %0d data %h, expected %h", mbeat, lxb2mm_data,
                                 req_line[owner][mbeat*MM_DBW +: MM_DBW]));
          mbeat++;
          mem_done = (mbeat == BEATS);
        end
      end
      if (lxb2mm_msg != NO_REQ && prev_msg != NO_REQ && !prev_hs &&
          (lxb2mm_address != prev_addr || lxb2mm_data != prev_data))
        flag_error("memory address or data changed during a stall");
      prev_msg  = lxb2mm_msg;
      prev_hs   = hs;
      prev_addr = lxb2mm_address;
      prev_data = lxb2mm_data;
      for (int c = 0; c < NUM_ULC; c++) begin
        slice = msg_out[c*MSGW +: MSGW];
        if (slice != MEM_NO_MSG) begin
          if (!open_req(c) || c != owner || !mem_done) begin
            flag_error($sformatf("unexpected response %0d on cache %0d", slice, c));
          end else begin
            if (slice != (is_wr[c] ? MEM_READY : MEM_SENT))
              flag_error($sformatf("cache %0d response code %0d is wrong", c, slice));
            if (out_address[c*ABW +: ABW] != req_addr[c])
              flag_error($sformatf("cache %0d out_address %h, expected %h", c,
                                   out_address[c*ABW +: ABW], req_addr[c]));
            for (int k = 0; k < BEATS; k++) begin
              if (is_wr[c])
                shadow[req_addr[c] + ABW'(k)] = req_line[c][k*MM_DBW +: MM_DBW];
              exp_line[k*MM_DBW +: MM_DBW] = shadow[req_addr[c] + ABW'(k)];
            end
            if (!is_wr[c] && data_out[c*ULC_DBW +: ULC_DBW] != exp_line)
              flag_error($sformatf("cache %0d read line %h, expected %h", c,
                                   data_out[c*ULC_DBW +: ULC_DBW], exp_line));
            resp_count[c]++;
            done_txn++;
            mem_done = 1'b0;
          end
        end
      end
      // Requests still waiting at this edge
      pend_d2 = pend_d1;
      for (int c = 0; c < NUM_ULC; c++) begin
        pend_d1[c] = open_req(c);
      end
      if (cycles >= MAX_CYCLES) begin
        $display("Timeout: only %0d of %0d transactions finished after %0d cycles",
                 done_txn, NUM_ULC * TXN_PER_CACHE, cycles);
        $display("Errors: %0d, transactions: %0d", errors, done_txn);
        $display("TESTBENCH FAILED");
        $finish;
      end
    end
  end

  initial begin
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset <= 1'b0;
    wait (done_txn == NUM_ULC * TXN_PER_CACHE);
    repeat (4) @(posedge clock);
    $display("Errors: %0d, transactions: %0d", errors, done_txn);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/mm_responder.sv */
`timescale 1ns/1ps
`default_nettype none

// Behavioral main memory, one beat per handshake after a random wait
module mm_responder #(
  parameter int          ABW  = 12,
  parameter logic [31:0] SEED = 32'h1
) (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire lx_pkg::msg_t               lxb2mm_msg,
  input  wire logic [ABW-1:0]             lxb2mm_address,
  input  wire logic [lx_pkg::MM_DBW-1:0]  lxb2mm_data,
  output lx_pkg::msg_t                    mm2lxb_msg,
  output logic [lx_pkg::MM_DBW-1:0]       mm2lxb_data
);
  import lx_pkg::*;

  logic [MM_DBW-1:0] mem [2**ABW];
  integer            seed;
  logic [31:0]       rnd;
  logic [1:0]        delay;  // Cycles left before the next answer

  // Every address gets its own word
  function automatic logic [MM_DBW-1:0] fill_word(input int a);
    return (32'(a) * 32'h9e3779b1) ^ 32'hc3c3c3c3;
  endfunction

  initial begin
    seed        = SEED;
    mm2lxb_msg  = MEM_NO_MSG;
    mm2lxb_data = '0;
    delay       = '0;
    for (int a = 0; a < 2**ABW; a++) begin
      mem[a] = fill_word(a);
    end
  end

  // Answers change on the falling edge, the bridge samples them on the rising one
  always @(negedge clock) begin
    mm2lxb_msg = MEM_NO_MSG;
    if (reset || lxb2mm_msg == NO_REQ) begin
      rnd   = $random(seed);
      delay = rnd[1:0];
    end else if (delay != 2'd0) begin
      delay = delay - 2'd1;  // Stall
    end else begin
      if (lxb2mm_msg == WB_REQ) begin
        mm2lxb_msg           = MEM_READY;
        mem[lxb2mm_address]  = lxb2mm_data;
      end else if (lxb2mm_msg == R_REQ) begin
        mm2lxb_msg  = MEM_SENT;
        mm2lxb_data = mem[lxb2mm_address];
      end
      rnd   = $random(seed);
      delay = rnd[1:0];
    end
  end

endmodule

`default_nettype wire

/* verilog/lxbypass_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lxbypass_top #(
  parameter int NUM_ULC = 2,
  parameter int ABW     = 12
) (
  input  wire logic                                clock,
  input  wire logic                                reset,

  // L1 side, one slice per cache
  input  wire logic [lx_pkg::MSGW*NUM_ULC-1:0]     msg_in,
  input  wire logic [ABW*NUM_ULC-1:0]              address,
  input  wire logic [lx_pkg::ULC_DBW*NUM_ULC-1:0]  data_in,
  output logic [lx_pkg::MSGW*NUM_ULC-1:0]          msg_out,
  output logic [ABW*NUM_ULC-1:0]                   out_address,
  output logic [lx_pkg::ULC_DBW*NUM_ULC-1:0]       data_out,

  // Main memory side
  input  wire lx_pkg::msg_t                        mm2lxb_msg,
  input  wire logic [lx_pkg::MM_DBW-1:0]           mm2lxb_data,
  output lx_pkg::msg_t                             lxb2mm_msg,
  output logic [ABW-1:0]                           lxb2mm_address,
  output logic [lx_pkg::MM_DBW-1:0]                lxb2mm_data
);

  // --------------------------------------------------------------------------
  // Internal buses
  // --------------------------------------------------------------------------
  lx_req_if  #(.NUM_ULC(NUM_ULC), .ABW(ABW)) req_bus ();
  lx_resp_if #(.NUM_ULC(NUM_ULC), .ABW(ABW)) resp_bus ();

  // --------------------------------------------------------------------------
  // Input side, memory side, output side
  // --------------------------------------------------------------------------
  ulc_request_arbiter #(.NUM_ULC(NUM_ULC), .ABW(ABW)) u_arbiter (
    .clock   (clock),
    .reset   (reset),
    .msg_in  (msg_in),
    .address (address),
    .data_in (data_in),
    .req     (req_bus.source)
  );

  mm_beat_sequencer #(.NUM_ULC(NUM_ULC), .ABW(ABW)) u_sequencer (
    .clock          (clock),
    .reset          (reset),
    .mm2lxb_msg     (mm2lxb_msg),
    .mm2lxb_data    (mm2lxb_data),
    .lxb2mm_msg     (lxb2mm_msg),
    .lxb2mm_address (lxb2mm_address),
    .lxb2mm_data    (lxb2mm_data),
    .req            (req_bus.sink),
    .resp           (resp_bus.source)
  );

  ulc_response_router #(.NUM_ULC(NUM_ULC), .ABW(ABW)) u_router (
    .clock       (clock),
    .reset       (reset),
    .resp        (resp_bus.sink),
    .msg_out     (msg_out),
    .out_address (out_address),
    .data_out    (data_out)
  );

endmodule

`default_nettype wire

/* verilog/ulc_response_router.sv */
`timescale 1ns/1ps
`default_nettype none

module ulc_response_router #(
  parameter int NUM_ULC = 2,
  parameter int ABW     = 12
) (
  input  wire logic                           clock,
  input  wire logic                           reset,
  lx_resp_if.sink                             resp,
  output logic [lx_pkg::MSGW*NUM_ULC-1:0]     msg_out,
  output logic [ABW*NUM_ULC-1:0]              out_address,
  output logic [lx_pkg::ULC_DBW*NUM_ULC-1:0]  data_out
);
  import lx_pkg::*;

  localparam int IDW = (NUM_ULC > 1) ? $clog2(NUM_ULC) : 1;

  msg_t               resp_msg;
  logic [ULC_DBW-1:0] resp_data;
  logic [NUM_ULC-1:0] slice_active;

  assign resp_msg  = resp.is_write ? MEM_READY : MEM_SENT;
  assign resp_data = resp.is_write ? '0 : resp.line.flat;  // Line only for reads

  // ------------------------------------------------------------------------
  // Demux toward the requesting cache
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      msg_out     <= '0;
      out_address <= '0;
      data_out    <= '0;
    end else if (resp.valid) begin
      for (int i = 0; i < NUM_ULC; i++) begin
        if (IDW'(i) == resp.id) begin
          msg_out[i*MSGW +: MSGW]           <= resp_msg;
          out_address[i*ABW +: ABW]         <= resp.address;
          data_out[i*ULC_DBW +: ULC_DBW]    <= resp_data;
        end else begin
          msg_out[i*MSGW +: MSGW]           <= MEM_NO_MSG;
          out_address[i*ABW +: ABW]         <= '0;
          data_out[i*ULC_DBW +: ULC_DBW]    <= '0;
        end
      end
    end else begin
      msg_out <= '0;  // Response lasts one cycle
    end
  end

  for (genvar g = 0; g < NUM_ULC; g++) begin : g_active
    assign slice_active[g] = |msg_out[g*MSGW +: MSGW];
  end

  one_slice_a: assert property (@(posedge clock) disable iff (reset)
    $onehot0(slice_active));

endmodule

`default_nettype wire

/* verilog/mm_beat_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_beat_sequencer #(
  parameter int NUM_ULC = 2,
  parameter int ABW     = 12
) (
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire lx_pkg::msg_t                mm2lxb_msg,
  input  wire logic [lx_pkg::MM_DBW-1:0]   mm2lxb_data,
  output lx_pkg::msg_t                     lxb2mm_msg,
  output logic [ABW-1:0]                   lxb2mm_address,
  output logic [lx_pkg::MM_DBW-1:0]        lxb2mm_data,
  lx_req_if.sink                           req,
  lx_resp_if.source                        resp
);
  import lx_pkg::*;

  localparam int IDW = (NUM_ULC > 1) ? $clog2(NUM_ULC) : 1;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WRITE = 2'd1;
  localparam logic [1:0] ST_READ  = 2'd2;

  logic [1:0] state;
  beat_idx_t  beat;
  beat_idx_t  next_beat;
  logic       wr_hs;
  logic       rd_hs;
  logic       handshake;
  logic       last_beat;
  line_u      rd_line;     // Beats gathered so far
  line_u      rd_view;     // Gathered beats plus the one on the bus

  // ------------------------------------------------------------------------
  // Memory handshake
  // ------------------------------------------------------------------------
  assign wr_hs     = (state == ST_WRITE) && (mm2lxb_msg == MEM_READY);
  assign rd_hs     = (state == ST_READ) && (mm2lxb_msg == MEM_SENT);
  assign handshake = wr_hs || rd_hs;
  assign next_beat = beat + 2'd1;
  assign last_beat = handshake && (beat == beat_idx_t'(BEATS - 1));

  // ------------------------------------------------------------------------
  // Unpack / pack FSM with address stepping
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state          <= ST_IDLE;
      beat           <= '0;
      lxb2mm_msg     <= NO_REQ;
      lxb2mm_address <= '0;
      lxb2mm_data    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req.start) begin
            state          <= req.is_write ? ST_WRITE : ST_READ;
            lxb2mm_msg     <= req.is_write ? WB_REQ : R_REQ;
            lxb2mm_address <= req.address;  // Base address on the first beat
            if (req.is_write) begin
              lxb2mm_data <= req.line.beat[0];
            end
          end
        end
        default: begin
          // Stall holds everything until memory answers
          if (handshake) begin
            beat <= next_beat;  // Wraps back to 0 after the last beat
            if (last_beat) begin
              state      <= ST_IDLE;
              lxb2mm_msg <= NO_REQ;
            end else begin
              lxb2mm_address <= lxb2mm_address + 1'b1;
              if (state == ST_WRITE) begin
                lxb2mm_data <= req.line.beat[next_beat];
              end
            end
          end
        end
      endcase
    end
  end

  // Read beats land low to high
  always_ff @(posedge clock) begin
    if (rd_hs) begin
      rd_line.beat[beat] <= mm2lxb_data;
    end
  end

  // Final beat goes straight through so the line is complete with valid
  always_comb begin
    rd_view                  = rd_line;
    rd_view.beat[BEATS-1]    = mm2lxb_data;
  end

  // ------------------------------------------------------------------------
  // Completion
  // ------------------------------------------------------------------------
  assign req.done      = last_beat;
  assign resp.valid    = last_beat;
  assign resp.is_write = (state == ST_WRITE);
  assign resp.id       = IDW'(req.id);
  assign resp.address  = req.address;  // Echo of the request address
  assign resp.line     = rd_view;

  beat_hold_a: assert property (@(posedge clock) disable iff (reset)
    !handshake |=> $stable(beat));

  // Arbiter must not launch while a burst is running
  start_idle_a: assert property (@(posedge clock) disable iff (reset)
    req.start |-> (state == ST_IDLE));

endmodule

`default_nettype wire

/* verilog/ulc_request_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ulc_request_arbiter #(
  parameter int NUM_ULC = 2,
  parameter int ABW     = 12
) (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire logic [lx_pkg::MSGW*NUM_ULC-1:0]     msg_in,
  input  wire logic [ABW*NUM_ULC-1:0]              address,
  input  wire logic [lx_pkg::ULC_DBW*NUM_ULC-1:0]  data_in,
  lx_req_if.source                                 req
);
  import lx_pkg::*;

  localparam int IDW = (NUM_ULC > 1) ? $clog2(NUM_ULC) : 1;

  logic [NUM_ULC-1:0] req_flag;
  logic [NUM_ULC-1:0] served;    // Answered, waiting for the cache to drop
  logic [NUM_ULC-1:0] pending;
  logic [IDW-1:0]     last_id;   // Round robin pointer
  logic [IDW-1:0]     grant_id;
  logic               found;
  logic               busy;
  logic               launch;

  // ------------------------------------------------------------------------
  // Request decode
  // ------------------------------------------------------------------------
  for (genvar g = 0; g < NUM_ULC; g++) begin : g_req
    assign req_flag[g] = (msg_in[g*MSGW +: MSGW] == WB_REQ) ||
                         (msg_in[g*MSGW +: MSGW] == R_REQ);
  end

  // A held request counts as new only once the cache has let go of it
  assign pending = req_flag & ~served;

  // Search starts just after the last cache served
  always_comb begin
    int idx;
    found    = 1'b0;
    grant_id = last_id;
    for (int k = 1; k <= NUM_ULC; k++) begin
      idx = int'(last_id) + k;
      if (idx >= NUM_ULC) idx = idx - NUM_ULC;
      if (!found && pending[idx]) begin
        found    = 1'b1;
        grant_id = IDW'(idx);
      end
    end
  end

  assign launch = found && !busy && !req.start;

  // ------------------------------------------------------------------------
  // Grant and transaction tracking
  // ------------------------------------------------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      req.start    <= 1'b0;
      req.is_write <= 1'b0;
      req.id       <= '0;
      busy         <= 1'b0;
      last_id      <= IDW'(NUM_ULC - 1);  // First pass begins at cache 0
      served       <= '0;
    end else begin
      req.start <= launch;
      served    <= served & req_flag;
      if (launch) begin
        req.is_write <= (msg_in[grant_id*MSGW +: MSGW] == WB_REQ);
        req.id       <= grant_id;
        last_id      <= grant_id;
      end
      if (req.start) busy <= 1'b1;
      if (req.done) begin
        busy            <= 1'b0;
        served[req.id]  <= 1'b1;
      end
    end
  end

  // Payload held for the whole open transaction
  always_ff @(posedge clock) begin
    if (launch) begin
      req.address   <= address[grant_id*ABW +: ABW];
      req.line.flat <= data_in[grant_id*ULC_DBW +: ULC_DBW];
    end
  end

  start_idle_a: assert property (@(posedge clock) disable iff (reset)
    req.start |-> !busy);

  // Sequencer may only close what was opened here
  done_open_a: assert property (@(posedge clock) disable iff (reset)
    req.done |-> busy);

endmodule

`default_nettype wire

/* verilog/lx_resp_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lx_resp_if #(
  parameter int NUM_ULC = 2,
  parameter int ABW     = 12
);
  import lx_pkg::*;

  localparam int IDW = (NUM_ULC > 1) ? $clog2(NUM_ULC) : 1;

  logic           valid;     // Single cycle completion
  logic           is_write;
  logic [IDW-1:0] id;
  logic [ABW-1:0] address;
  line_u          line;      // Read data

  modport source (output valid, is_write, id, address, line);
  modport sink   (input valid, is_write, id, address, line);

endinterface

`default_nettype wire

/* verilog/lx_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Accepted request, arbiter to beat sequencer
interface lx_req_if #(
  parameter int NUM_ULC = 2,
  parameter int ABW     = 12
);
  import lx_pkg::*;

  localparam int IDW = (NUM_ULC > 1) ? $clog2(NUM_ULC) : 1;

  logic           start;     // One cycle, only while nothing is open
  logic           is_write;
  logic [IDW-1:0] id;
  logic [ABW-1:0] address;
  line_u          line;
  logic           done;      // Closes the transaction

  modport source (output start, is_write, id, address, line, input done);
  modport sink   (input start, is_write, id, address, line, output done);

endinterface

`default_nettype wire

/* verilog/lx_pkg.sv */
`default_nettype none

package lx_pkg;

  // ------------------------------------------------------------------------
  // Message encoding shared by the L1 side and the memory side
  // ------------------------------------------------------------------------
  localparam int MSGW = 3;

  typedef logic [MSGW-1:0] msg_t;

  // Requests toward memory, also used by the caches
  localparam msg_t NO_REQ = 3'd0;
  localparam msg_t WB_REQ = 3'd1;
  localparam msg_t R_REQ  = 3'd2;

  // Responses
  localparam msg_t MEM_NO_MSG = 3'd0;
  localparam msg_t MEM_READY  = 3'd1;  // Write beat taken / write-back done
  localparam msg_t MEM_SENT   = 3'd2;  // Read beat valid / line delivered

  // ------------------------------------------------------------------------
  // Bus widths and the cache line
  // ------------------------------------------------------------------------
  localparam int ULC_DBW = 128;  // L1 line
  localparam int MM_DBW  = 32;   // Memory beat
  localparam int BEATS   = ULC_DBW / MM_DBW;

  typedef logic [1:0] beat_idx_t;

  // Same 128 bits seen as one word or as beats, beat 0 lowest
  typedef union packed {
    logic [ULC_DBW-1:0]            flat;
    logic [BEATS-1:0][MM_DBW-1:0]  beat;
  } line_u;

endpackage

`default_nettype wire
